// ==== src/rv_core_consts.svh ====
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// Data and instruction width
`define XLEN 32

// Unified RAM depth in words
`define RAM_WORDS 1024

`define RESET_PC 32'h0000_0000

// One multiplier bit per cycle
`define MUL_CYCLES 32

`endif

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OPIMM  = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SRA = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLL = 4'd7,
        ALU_SLT = 4'd8,
        ALU_EQ  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {IMM_I, IMM_S, IMM_SB, IMM_UJ} imm_sel_e;

    typedef struct packed {
        logic    alusrc;
        alu_op_e aluop;
        logic    jal;
        logic    jalr;
        logic    branch;
        logic    bne;         // Invert EQ result
        logic    mem_to_reg;
        logic    mem_wen;
        logic    mem_ren;
        logic    reg_wen;
        logic    mul;
    } ctrl_t;

endpackage

// ==== src/rv_bus_pkg.sv ====
`include "rv_core_consts.svh"

package rv_bus_pkg;

    typedef logic [`XLEN-1:0] word_t;

    typedef logic [$clog2(`RAM_WORDS)-1:0] waddr_t;

    // Requester identity, DATA wins arbitration
    typedef enum logic {
        SRC_FETCH = 1'b0,
        SRC_DATA  = 1'b1
    } bus_src_e;

endpackage

// ==== src/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if;

    logic               req;
    logic               we;
    rv_bus_pkg::waddr_t addr;
    rv_bus_pkg::word_t  wdata;
    logic               gnt;
    logic               rvalid;
    rv_bus_pkg::word_t  rdata;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport ram (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

// ==== src/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  rv_bus_pkg::word_t  inst_i,
    output logic [4:0]         rs1_o,
    output logic [4:0]         rs2_o,
    output logic [4:0]         rd_o,
    output rv_bus_pkg::word_t  imm_o,
    output rv_isa_pkg::ctrl_t  ctrl_o
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    rv_isa_pkg::imm_sel_e imm_sel;
    rv_isa_pkg::alu_op_e  arith_op;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];
    assign rd_o   = inst_i[11:7];

    // Shared by OP and OPIMM, funct7[5] only matters for SUB and SRA
    always_comb begin
        case (funct3)
            3'b000:  arith_op = rv_isa_pkg::ALU_ADD;
            3'b001:  arith_op = rv_isa_pkg::ALU_SLL;
            3'b010:  arith_op = rv_isa_pkg::ALU_SLT;
            3'b100:  arith_op = rv_isa_pkg::ALU_XOR;
            3'b101:  arith_op = funct7[5] ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            3'b110:  arith_op = rv_isa_pkg::ALU_OR;
            default: arith_op = rv_isa_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl_o       = '0;
        ctrl_o.aluop = rv_isa_pkg::ALU_ADD;
        imm_sel      = rv_isa_pkg::IMM_I;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                ctrl_o.reg_wen = 1'b1;
                ctrl_o.aluop   = arith_op;
                if (funct3 == 3'b000 && funct7[5]) begin
                    ctrl_o.aluop = rv_isa_pkg::ALU_SUB;
                end
                ctrl_o.mul = (funct3 == 3'b000) && funct7[0]; // MUL, low word
            end
            rv_isa_pkg::OPC_OPIMM: begin
                ctrl_o.alusrc  = 1'b1;
                ctrl_o.reg_wen = 1'b1;
                ctrl_o.aluop   = arith_op;
            end
            rv_isa_pkg::OPC_LOAD: begin
                ctrl_o.alusrc     = 1'b1;
                ctrl_o.mem_ren    = 1'b1;
                ctrl_o.mem_to_reg = 1'b1;
                ctrl_o.reg_wen    = 1'b1;
            end
            rv_isa_pkg::OPC_STORE: begin
                ctrl_o.alusrc  = 1'b1;
                ctrl_o.mem_wen = 1'b1;
                imm_sel        = rv_isa_pkg::IMM_S;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                ctrl_o.branch = 1'b1;
                ctrl_o.aluop  = rv_isa_pkg::ALU_EQ;
                ctrl_o.bne    = funct3[0];  // BNE
                imm_sel       = rv_isa_pkg::IMM_SB;
            end
            rv_isa_pkg::OPC_JAL: begin
                ctrl_o.jal     = 1'b1;
                ctrl_o.reg_wen = 1'b1;
                imm_sel        = rv_isa_pkg::IMM_UJ;
            end
            rv_isa_pkg::OPC_JALR: begin
                ctrl_o.jalr    = 1'b1;
                ctrl_o.alusrc  = 1'b1;
                ctrl_o.reg_wen = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (imm_sel)
            rv_isa_pkg::IMM_S:  imm_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            rv_isa_pkg::IMM_SB: imm_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                                         inst_i[30:25], inst_i[11:8], 1'b0};
            rv_isa_pkg::IMM_UJ: imm_o = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                                         inst_i[20], inst_i[30:21], 1'b0};
            default:            imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
        endcase
    end

endmodule

// ==== src/multiplier.sv ====
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module multiplier (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              start_i,
    input  rv_bus_pkg::word_t a_i,
    input  rv_bus_pkg::word_t b_i,
    output logic              busy_o,
    output logic              done_o,
    output rv_bus_pkg::word_t product_o
);

    rv_bus_pkg::word_t mcand_q;
    rv_bus_pkg::word_t mplier_q;
    logic [$clog2(`MUL_CYCLES+1)-1:0] count_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_o  <= 1'b0;
            done_o  <= 1'b0;
            count_q <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i && !busy_o) begin
                busy_o    <= 1'b1;
                count_q   <= `MUL_CYCLES;
                mcand_q   <= a_i;
                mplier_q  <= b_i;
                product_o <= '0;
            end else if (busy_o) begin
                if (mplier_q[0]) begin
                    product_o <= product_o + mcand_q;
                end
                mcand_q  <= mcand_q << 1;
                mplier_q <= mplier_q >> 1;
                count_q  <= count_q - 1'b1;
                if (count_q == 1) begin  // Last iteration
                    busy_o <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module fetch_unit (
    input  logic              clk_i,
    input  logic              rst_n_i,
    mem_bus_if.requester      bus,
    input  logic              instr_ack_i,
    input  logic              redirect_i,
    input  rv_bus_pkg::word_t redirect_pc_i,
    output logic              instr_valid_o,
    output rv_bus_pkg::word_t instr_o,
    output rv_bus_pkg::word_t pc_o
);

    rv_bus_pkg::word_t fetch_pc_q;
    rv_bus_pkg::word_t pend_pc_q;
    logic pend_q;

    // Next word may go out as soon as the current one is acked
    assign bus.req   = !pend_q && (!instr_valid_o || (instr_ack_i && !redirect_i));
    assign bus.we    = 1'b0;
    assign bus.wdata = '0;
    assign bus.addr  = fetch_pc_q[$bits(rv_bus_pkg::waddr_t)+1:2];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fetch_pc_q    <= `RESET_PC;
            pend_q        <= 1'b0;
            instr_valid_o <= 1'b0;
        end else begin
            if (bus.req && bus.gnt) begin
                pend_q     <= 1'b1;
                pend_pc_q  <= fetch_pc_q;
                fetch_pc_q <= fetch_pc_q + 32'd4;
            end else if (bus.rvalid) begin
                pend_q <= 1'b0;
            end
            if (redirect_i) begin
                fetch_pc_q    <= redirect_pc_i;
                instr_valid_o <= 1'b0;
            end else if (instr_ack_i) begin
                instr_valid_o <= 1'b0;
            end
            if (bus.rvalid) begin
                if (!redirect_i) begin
                    instr_valid_o <= 1'b1;
                    instr_o       <= bus.rdata;
                    pc_o          <= pend_pc_q;
                end
            end
        end
    end

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  logic              clk_i,
    input  logic              rst_n_i,
    mem_bus_if.requester      bus,
    input  logic              instr_valid_i,
    input  rv_bus_pkg::word_t pc_i,
    input  logic [4:0]        rs1_i,
    input  logic [4:0]        rs2_i,
    input  logic [4:0]        rd_i,
    input  rv_bus_pkg::word_t imm_i,
    input  rv_isa_pkg::ctrl_t ctrl_i,
    output logic              instr_ack_o,
    output logic              redirect_o,
    output rv_bus_pkg::word_t redirect_pc_o,
    output logic              mul_start_o,
    output rv_bus_pkg::word_t mul_a_o,
    output rv_bus_pkg::word_t mul_b_o,
    input  logic              mul_done_i,
    input  rv_bus_pkg::word_t mul_product_i,
    output logic              retire_o,
    output rv_bus_pkg::word_t retire_pc_o,
    output logic [4:0]        retire_rd_o,
    output logic              retire_we_o,
    output rv_bus_pkg::word_t retire_data_o
);

    typedef enum logic [1:0] {S_IDLE, S_MEM_REQ, S_MEM_WAIT, S_MUL_WAIT} state_e;

    state_e state_q;
    rv_bus_pkg::word_t regs_q [31:1];
    rv_bus_pkg::word_t op_a, op_b, rs2_val, alu_res, wb_data;
    logic plain, finish, taken;

    assign op_a    = (rs1_i == 5'd0) ? '0 : regs_q[rs1_i];
    assign rs2_val = (rs2_i == 5'd0) ? '0 : regs_q[rs2_i];
    assign op_b    = ctrl_i.alusrc ? imm_i : rs2_val;

    always_comb begin
        case (ctrl_i.aluop)
            rv_isa_pkg::ALU_SUB: alu_res = op_a - op_b;
            rv_isa_pkg::ALU_AND: alu_res = op_a & op_b;
            rv_isa_pkg::ALU_OR:  alu_res = op_a | op_b;
            rv_isa_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            rv_isa_pkg::ALU_SRA: alu_res = $signed(op_a) >>> op_b[4:0];
            rv_isa_pkg::ALU_SRL: alu_res = op_a >> op_b[4:0];
            rv_isa_pkg::ALU_SLL: alu_res = op_a << op_b[4:0];
            rv_isa_pkg::ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_isa_pkg::ALU_EQ:  alu_res = {31'b0, op_a == op_b};
            default:             alu_res = op_a + op_b;
        endcase
    end

    // Single-cycle class: ALU, branches and jumps
    assign plain = !(ctrl_i.mem_ren || ctrl_i.mem_wen || ctrl_i.mul);
    assign finish = (state_q == S_IDLE && instr_valid_i && plain)
                 || (state_q == S_MEM_REQ && bus.gnt && ctrl_i.mem_wen)
                 || (state_q == S_MEM_WAIT && bus.rvalid)
                 || (state_q == S_MUL_WAIT && mul_done_i);
    assign instr_ack_o = finish;

    assign taken         = ctrl_i.branch && (alu_res[0] ^ ctrl_i.bne);
    assign redirect_o    = finish && (ctrl_i.jal || ctrl_i.jalr || taken);
    assign redirect_pc_o = ctrl_i.jalr ? (alu_res & ~32'd1) : pc_i + imm_i;

    always_comb begin
        if (ctrl_i.jal || ctrl_i.jalr) wb_data = pc_i + 32'd4;  // Link value
        else if (ctrl_i.mem_to_reg)    wb_data = bus.rdata;
        else if (ctrl_i.mul)           wb_data = mul_product_i;
        else                           wb_data = alu_res;
    end

    assign bus.req     = (state_q == S_MEM_REQ);
    assign bus.we      = ctrl_i.mem_wen;
    assign bus.addr    = alu_res[$bits(rv_bus_pkg::waddr_t)+1:2];
    assign bus.wdata   = rs2_val;
    assign mul_start_o = (state_q == S_IDLE) && instr_valid_i && ctrl_i.mul;
    assign mul_a_o     = op_a;
    assign mul_b_o     = rs2_val;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= S_IDLE;
            retire_o <= 1'b0;
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            retire_o <= finish;
            case (state_q)
                S_IDLE:
                    if (instr_valid_i && ctrl_i.mul)  state_q <= S_MUL_WAIT;
                    else if (instr_valid_i && !plain) state_q <= S_MEM_REQ;
                S_MEM_REQ:
                    if (bus.gnt) state_q <= ctrl_i.mem_wen ? S_IDLE : S_MEM_WAIT;
                default:
                    if (finish) state_q <= S_IDLE;
            endcase
            if (finish) begin
                retire_pc_o   <= pc_i;
                retire_rd_o   <= rd_i;
                retire_we_o   <= ctrl_i.reg_wen && (rd_i != 5'd0);
                retire_data_o <= wb_data;
                if (ctrl_i.reg_wen && rd_i != 5'd0) begin
                    regs_q[rd_i] <= wb_data;
                end
            end
        end
    end

endmodule

// ==== src/arbitrated_ram.sv ====
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module arbitrated_ram (
    input  logic               clk_i,
    input  logic               rst_n_i,
    mem_bus_if.ram             fetch_bus,
    mem_bus_if.ram             data_bus,
    input  logic               load_we_i,
    input  rv_bus_pkg::waddr_t load_addr_i,
    input  rv_bus_pkg::word_t  load_data_i
);

    rv_bus_pkg::word_t  mem [`RAM_WORDS];
    rv_bus_pkg::word_t  rdata_q;
    rv_bus_pkg::bus_src_e src_q;
    rv_bus_pkg::bus_src_e src;
    rv_bus_pkg::waddr_t addr;
    logic rd_pend_q;
    logic any_gnt;

    // Fixed priority, data port first
    assign data_bus.gnt  = rst_n_i && data_bus.req;
    assign fetch_bus.gnt = rst_n_i && fetch_bus.req && !data_bus.req;
    assign any_gnt       = data_bus.gnt || fetch_bus.gnt;
    assign src           = data_bus.gnt ? rv_bus_pkg::SRC_DATA : rv_bus_pkg::SRC_FETCH;
    assign addr          = data_bus.gnt ? data_bus.addr : fetch_bus.addr;

    assign data_bus.rdata   = rdata_q;
    assign fetch_bus.rdata  = rdata_q;
    assign data_bus.rvalid  = rd_pend_q && (src_q == rv_bus_pkg::SRC_DATA);
    assign fetch_bus.rvalid = rd_pend_q && (src_q == rv_bus_pkg::SRC_FETCH);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            if (load_we_i) begin
                mem[load_addr_i] <= load_data_i;  // Program load
            end
        end else if (data_bus.gnt && data_bus.we) begin
            mem[addr] <= data_bus.wdata;
        end
        rdata_q <= mem[addr];
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_pend_q <= 1'b0;
            src_q     <= rv_bus_pkg::SRC_FETCH;
        end else begin
            rd_pend_q <= any_gnt && !(data_bus.gnt && data_bus.we);
            src_q     <= src;
        end
    end

endmodule

// ==== src/rv_soc_top.sv ====
`timescale 1ns/1ps

module rv_soc_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               load_we_i,
    input  rv_bus_pkg::waddr_t load_addr_i,
    input  rv_bus_pkg::word_t  load_data_i,
    output logic               retire_o,
    output rv_bus_pkg::word_t  retire_pc_o,
    output logic [4:0]         retire_rd_o,
    output logic               retire_we_o,
    output rv_bus_pkg::word_t  retire_data_o
);

    mem_bus_if fetch_bus ();
    mem_bus_if data_bus ();

    rv_bus_pkg::word_t instr, pc, imm, redirect_pc, mul_a, mul_b, product;
    rv_isa_pkg::ctrl_t ctrl;
    logic [4:0] rs1, rs2, rd;
    logic instr_valid, instr_ack, redirect, mul_start, mul_done;

    fetch_unit i_fetch_unit (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .bus(fetch_bus),
        .instr_ack_i(instr_ack), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .instr_valid_o(instr_valid), .instr_o(instr), .pc_o(pc)
    );

    decoder i_decoder (
        .inst_i(instr), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm), .ctrl_o(ctrl)
    );

    exec_unit i_exec_unit (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .bus(data_bus),
        .instr_valid_i(instr_valid), .pc_i(pc), .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd),
        .imm_i(imm), .ctrl_i(ctrl), .instr_ack_o(instr_ack), .redirect_o(redirect),
        .redirect_pc_o(redirect_pc), .mul_start_o(mul_start), .mul_a_o(mul_a),
        .mul_b_o(mul_b), .mul_done_i(mul_done), .mul_product_i(product),
        .retire_o(retire_o), .retire_pc_o(retire_pc_o), .retire_rd_o(retire_rd_o),
        .retire_we_o(retire_we_o), .retire_data_o(retire_data_o)
    );

    multiplier i_multiplier (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .start_i(mul_start), .a_i(mul_a), .b_i(mul_b),
        .busy_o(), .done_o(mul_done), .product_o(product)
    );

    arbitrated_ram i_arbitrated_ram (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .fetch_bus(fetch_bus), .data_bus(data_bus),
        .load_we_i(load_we_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i)
    );

endmodule

// ==== verification/rv_soc_props.sv ====
`timescale 1ns/1ps

module rv_soc_props (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 fetch_gnt_i,
    input logic                 data_gnt_i,
    input logic                 data_we_i,
    input logic                 fetch_rvalid_i,
    input logic                 data_rvalid_i,
    input rv_bus_pkg::bus_src_e src_i
);

    logic rd_gnt;

    assign rd_gnt = fetch_gnt_i || (data_gnt_i && !data_we_i);  // Any granted read

    single_grant: assert property (@(posedge clk_i) !(fetch_gnt_i && data_gnt_i))
        else $error("fetch and data ports granted in the same cycle");

    data_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_gnt && src_i == rv_bus_pkg::SRC_DATA |=> data_rvalid_i && !fetch_rvalid_i)
        else $error("data read not answered one cycle after its grant");

    fetch_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_gnt && src_i == rv_bus_pkg::SRC_FETCH |=> fetch_rvalid_i && !data_rvalid_i)
        else $error("fetch read not answered one cycle after its grant");

    reset_no_gnt: assert property (@(posedge clk_i) !rst_n_i |-> !(fetch_gnt_i || data_gnt_i))
        else $error("RAM grant while reset is held");

endmodule

bind arbitrated_ram rv_soc_props i_rv_soc_props (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .fetch_gnt_i(fetch_bus.gnt), .data_gnt_i(data_bus.gnt), .data_we_i(data_bus.we),
    .fetch_rvalid_i(fetch_bus.rvalid), .data_rvalid_i(data_bus.rvalid),
    .src_i(src)
);

// ==== verification/rv_soc_tb.sv ====
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_soc_tb;

    localparam int DATA_BASE  = 448;   // First word of the load/store region
    localparam int DATA_WORDS = 16;
    localparam int LOAD_WORDS = DATA_BASE + DATA_WORDS;
    localparam int JBASE      = 1024;  // Byte address kept in x31 for JALR
    localparam int TIMEOUT    = 200;
    localparam int MIX_ALU    = 0;
    localparam int MIX_MEM    = 1;
    localparam int MIX_BRANCH = 2;
    localparam int MIX_MUL    = 3;
    localparam int MIX_ALL    = 4;

    logic clk = 1'b0;
    logic rst_n;
    logic load_we;
    rv_bus_pkg::waddr_t load_addr;
    rv_bus_pkg::word_t  load_data;
    logic retire;
    logic retire_we;
    logic [4:0] retire_rd;
    rv_bus_pkg::word_t retire_pc;
    rv_bus_pkg::word_t retire_data;

    logic [31:0] ram_img [LOAD_WORDS];  // Loaded image, also the model's memory
    logic [31:0] mreg [32];
    logic [31:0] m_pc;
    logic [31:0] rng;
    string test_name;
    int errors;
    int test_errors;
    int tests;
    int failed_tests;
    logic timed_out;

    rv_soc_top i_rv_soc_top (
        .clk_i(clk), .rst_n_i(rst_n),
        .load_we_i(load_we), .load_addr_i(load_addr), .load_data_i(load_data),
        .retire_o(retire), .retire_pc_o(retire_pc), .retire_rd_o(retire_rd),
        .retire_we_o(retire_we), .retire_data_o(retire_data)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rv_isa_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OPC_JAL};
    endfunction

    // One random instruction at word p, control flow only forward up to the last word
    function automatic logic [31:0] gen_instr(input int p, input int last, input int mix);
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0] rd;
        logic [2:0] f3;
        logic [11:0] imm;
        int kind;
        int tgt;
        r   = xorshift32();
        r2  = xorshift32();
        rd  = 5'(r % 32'd31);  // Never x31
        f3  = r[18:16];
        tgt = p + 1 + int'(r2[1:0]);
        if (tgt > last) tgt = last;
        case (mix)
            MIX_ALU: kind = int'(r[15:8]) % 2;
            MIX_MEM: kind = int'(r[15:8]) % 4;
            MIX_BRANCH: begin
                kind = int'(r[15:8]) % 5;
                if (kind > 1) kind = kind + 2;
            end
            MIX_MUL: kind = r[8] ? 7 : 1;
            default: kind = int'(r[15:8]) % 8;
        endcase
        case (kind)
            0: begin
                if (f3 == 3'b011) f3 = 3'b000;  // No SLTU
                return enc_r((r[29] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0,
                             r[28:24], r[23:19], f3, rd);
            end
            1: begin
                if (f3 == 3'b011) f3 = 3'b111;
                imm = r2[31:20];
                if (f3 == 3'b001) imm = {7'b0, r2[24:20]};
                if (f3 == 3'b101) imm = {1'b0, r[29], 5'b0, r2[24:20]};
                return enc_i(imm, r[23:19], f3, rd, rv_isa_pkg::OPC_OPIMM);
            end
            2: return enc_s(12'(DATA_BASE * 4) + {6'b0, r2[5:2], 2'b0}, r[28:24]);
            3: return enc_i(12'(DATA_BASE * 4) + {6'b0, r2[5:2], 2'b0}, 5'd0, 3'b010, rd,
                            rv_isa_pkg::OPC_LOAD);
            4: return enc_b(13'((tgt - p) * 4), {2'b0, r[26:24]}, {2'b0, r[21:19]},
                            {2'b0, r[16]});
            5: return enc_j(21'((tgt - p) * 4), rd);
            6: return enc_i(12'(tgt * 4 - JBASE), 5'd31, 3'b000, rd, rv_isa_pkg::OPC_JALR);
            default: return enc_r(7'b0000001, r[28:24], r[23:19], 3'b000, rd);
        endcase
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'd0, $signed(a) < $signed(b)};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_program(input int mix, input int len);
        for (int w = 0; w < LOAD_WORDS; w++) begin
            ram_img[w] = (w >= DATA_BASE) ? (32'(w) * 32'h9E37_79B9) ^ 32'h0F0F_5A5A : 32'd0;
        end
        ram_img[0] = enc_i(12'(JBASE), 5'd0, 3'b000, 5'd31, rv_isa_pkg::OPC_OPIMM);
        for (int p = 1; p < len - 1; p++) begin
            ram_img[p] = gen_instr(p, len - 1, mix);
        end
        ram_img[len - 1] = enc_j(21'd0, 5'd0);  // Self-jump
    endtask

    // Executes one instruction of the image and returns what should retire
    task automatic model_step(output logic [31:0] e_pc, output logic [4:0] e_rd,
                              output logic e_we, output logic [31:0] e_data);
        logic [31:0] ins, a, b, imm_i, imm_s, imm_b, imm_j, res, npc;
        logic wr;
        ins   = ram_img[m_pc[11:2]];
        a     = mreg[ins[19:15]];
        b     = mreg[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        npc   = m_pc + 32'd4;
        res   = 32'd0;
        wr    = 1'b1;
        case (ins[6:0])
            rv_isa_pkg::OPC_OP:
                res = (ins[31:25] == 7'b0000001) ? a * b : alu_model(ins[14:12], ins[30], a, b);
            rv_isa_pkg::OPC_OPIMM:
                res = alu_model(ins[14:12], ins[14:12] == 3'b101 && ins[30], a, imm_i);
            rv_isa_pkg::OPC_LOAD:
                res = ram_img[10'((a + imm_i) >> 2)];
            rv_isa_pkg::OPC_STORE: begin
                ram_img[10'((a + imm_s) >> 2)] = b;
                wr = 1'b0;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                wr = 1'b0;
                if ((a == b) != ins[12]) npc = m_pc + imm_b;  // BNE when funct3[0]
            end
            rv_isa_pkg::OPC_JAL: begin
                res = m_pc + 32'd4;
                npc = m_pc + imm_j;
            end
            default: begin
                res = m_pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
        endcase
        e_pc   = m_pc;
        e_rd   = ins[11:7];
        e_we   = wr && ins[11:7] != 5'd0;
        e_data = res;
        if (e_we) mreg[ins[11:7]] = res;
        m_pc = npc;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %h actual %h", test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic run_test(input string name, input int mix, input int len, input int count);
        logic [31:0] e_pc;
        logic [31:0] e_data;
        logic [4:0] e_rd;
        logic e_we;
        logic seen;
        if (timed_out) return;
        test_name   = name;
        test_errors = 0;
        tests++;
        build_program(mix, len);
        foreach (mreg[i]) mreg[i] = 32'd0;
        m_pc  = `RESET_PC;
        rst_n = 1'b0;
        // Image is written while reset is held, then 4 more reset cycles
        for (int i = 0; i < LOAD_WORDS + 4; i++) begin
            @(negedge clk);
            check_value("retire during reset", 32'd0, {31'd0, retire});
            load_we   = (i < LOAD_WORDS);
            load_addr = rv_bus_pkg::waddr_t'(i);
            load_data = ram_img[i % LOAD_WORDS];
        end
        @(negedge clk);
        rst_n = 1'b1;
        for (int r = 0; r < count && !timed_out; r++) begin
            seen = 1'b0;
            for (int n = 0; n < TIMEOUT && !seen; n++) begin
                @(negedge clk);
                seen = retire;
            end
            if (!seen) begin
                $display("Test %s: no retirement within %0d cycles, the core is stuck",
                         name, TIMEOUT);
                timed_out = 1'b1;
            end else begin
                model_step(e_pc, e_rd, e_we, e_data);
                if (r == 0) check_value("first pc", `RESET_PC, retire_pc);
                check_value("pc", e_pc, retire_pc);
                check_value("rd", {27'd0, e_rd}, {27'd0, retire_rd});
                check_value("we", {31'd0, e_we}, {31'd0, retire_we});
                if (e_we) check_value("data", e_data, retire_data);
            end
        end
        if (test_errors != 0 || timed_out) failed_tests++;
        $display("Test %s %s with %0d errors", name,
                 (test_errors == 0 && !timed_out) ? "passed" : "failed", test_errors);
    endtask

    initial begin
        rst_n        = 1'b0;
        load_we      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        rng          = 32'd46087;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        run_test("reset", MIX_ALU, 12, 16);
        run_test("alu", MIX_ALU, 60, 60);
        run_test("mem", MIX_MEM, 60, 60);
        run_test("branch", MIX_BRANCH, 80, 60);
        run_test("mul", MIX_MUL, 30, 30);
        run_test("mixed", MIX_ALL, 420, 400);
        $display("Tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+src
src/rv_isa_pkg.sv
src/rv_bus_pkg.sv
src/mem_bus_if.sv
src/decoder.sv
src/multiplier.sv
src/fetch_unit.sv
src/exec_unit.sv
src/arbitrated_ram.sv
src/rv_soc_top.sv
verification/rv_soc_props.sv
verification/rv_soc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_soc_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SOURCES := $(wildcard src/*.sv src/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
